/* vlog.f */
source/rv_isa_pkg.sv
source/otter_pipe_pkg.sv
source/dmem_if.sv
source/fetch_stage.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/data_memory.sv
source/otter_pipeline.sv
verif/otter_pipeline_properties.sv
verif/tb_otter_pipeline.sv

/* verif/tb_otter_pipeline.sv */
module tb_otter_pipeline import rv_isa_pkg::*, otter_pipe_pkg::*; ();

    localparam int NUM_TESTS = 6;
    localparam int BODY_LEN  = 40;
    // Worst case: LUI, 30 inits, body with two NOPs each, dump plus NOPs
    localparam int MAX_PROG    = 1 + 30 + 3 * BODY_LEN + 32;
    // Boot load plus run, for every test
    localparam int CYCLE_LIMIT = NUM_TESTS * (MAX_PROG + IMEM_WORDS + 20);
    localparam instr_t     NOP     = 32'h0000_0013;
    localparam logic [2:0] F3_WORD = 3'b010;

    logic       CLOCK;
    logic       RESET;
    logic       prog_we;
    imem_addr_t prog_addr;
    instr_t     prog_data;
    word_t      iobus_in;
    word_t      iobus_out;
    word_t      iobus_addr;
    logic       iobus_wr;

    otter_pipeline u_dut (
        .CLOCK      (CLOCK),
        .RESET      (RESET),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .iobus_in   (iobus_in),
        .iobus_out  (iobus_out),
        .iobus_addr (iobus_addr),
        .iobus_wr   (iobus_wr)
    );

    bind otter_pipeline otter_pipeline_properties u_props (
        .CLOCK      (CLOCK),
        .RESET      (RESET),
        .iobus_wr   (iobus_wr),
        .iobus_addr (iobus_addr)
    );

    initial CLOCK = 1'b0;
    always #50 CLOCK = ~CLOCK;

    // Stimulus and model state
    logic [31:0] lfsr = 32'h68f9dfe1;
    instr_t      prog [IMEM_WORDS];
    int          prog_len;
    reg_idx_t    hist0;
    reg_idx_t    hist1;
    word_t       regs_m [32];
    word_t       dmem_m [DMEM_WORDS];
    logic        dmem_ok [DMEM_WORDS];
    word_t       io_val;
    word_t       exp_addr [$];
    word_t       exp_data [$];
    int          cycles;
    logic        reset_q;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_addr(input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: iobus_addr = %h, expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_data(input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: iobus_out = %h, expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: iobus_wr = %b, expected %b",
                                $time, got, exp));
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // x1..x30, x31 stays the IO base
    function automatic reg_idx_t pick_rd();
        return reg_idx_t'(next_bits(5) % 30 + 1);
    endfunction

    function automatic reg_idx_t pick_rs();
        return reg_idx_t'(next_bits(5) % 31);
    endfunction

    function automatic word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Encoders and reference ALU
    ////////////////////////////////////////////////////////////////////

    function automatic instr_t enc_r(input logic alt, input reg_idx_t rs2, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd, input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                     input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                     input opcode_t op);
        return {imm, rd, op};
    endfunction

    // RV32I integer semantics
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> sh) : a >> sh;
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Program generator with model
    ////////////////////////////////////////////////////////////////////

    // Source written by one of the last two instructions
    function automatic logic hazard(input reg_idx_t r);
        return (r != '0) && ((r == hist0) || (r == hist1));
    endfunction

    task automatic push_instr(input instr_t ins, input reg_idx_t rd);
        prog[prog_len] = ins;
        prog_len++;
        hist1 = hist0;
        hist0 = rd;
    endtask

    // NOPs keep two slots between writer and reader
    task automatic emit(input instr_t ins, input reg_idx_t rd, input reg_idx_t s1,
                        input reg_idx_t s2);
        while (hazard(s1) || hazard(s2)) begin
            push_instr(NOP, '0);
        end
        push_instr(ins, rd);
    endtask

    task automatic add_data_store(input reg_idx_t rs2);
        dmem_addr_t idx;
        idx = dmem_addr_t'(next_bits(8));
        emit(enc_s({2'b00, idx, 2'b00}, rs2, 5'd0), 5'd0, 5'd0, rs2);
        dmem_m[idx]  = regs_m[rs2];
        dmem_ok[idx] = 1'b1;
    endtask

    task automatic add_io_store(input reg_idx_t rs2, input logic [11:0] off);
        emit(enc_s(off, rs2, 5'd31), 5'd0, 5'd31, rs2);
        exp_addr.push_back(IO_BASE + word_t'(off));
        exp_data.push_back(regs_m[rs2]);
    endtask

    task automatic add_random_instr();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        logic [19:0] uimm;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        dmem_addr_t  idx;
        kind = 3'(next_bits(3));
        rd   = pick_rd();
        rs1  = pick_rs();
        rs2  = pick_rs();
        case (kind)
            3'd0, 3'd1: begin
                f3  = 3'(next_bits(3));
                alt = ((f3 == F3_ADD_SUB) || (f3 == F3_SRL_SRA)) ? 1'(next_bits(1)) : 1'b0;
                emit(enc_r(alt, rs2, rs1, f3, rd), rd, rs1, rs2);
                regs_m[rd] = alu_ref(f3, alt, regs_m[rs1], regs_m[rs2]);
            end
            3'd2, 3'd3: begin
                f3  = 3'(next_bits(3));
                imm = 12'(next_bits(12));
                // Shifts carry a shamt, bit 10 picks SRAI
                if (f3 == F3_SLL) begin
                    imm = {7'b0, imm[4:0]};
                end else if (f3 == F3_SRL_SRA) begin
                    imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                end
                alt = (f3 == F3_SRL_SRA) && imm[10];
                emit(enc_i(imm, rs1, f3, rd, OPC_OP_IMM), rd, rs1, 5'd0);
                regs_m[rd] = alu_ref(f3, alt, regs_m[rs1], sext12(imm));
            end
            3'd4: begin
                uimm = 20'(next_bits(20));
                if (next_bits(1) != 0) begin
                    emit(enc_u(uimm, rd, OPC_LUI), rd, 5'd0, 5'd0);
                    regs_m[rd] = {uimm, 12'b0};
                end else begin
                    emit(enc_u(uimm, rd, OPC_AUIPC), rd, 5'd0, 5'd0);
                    // Own pc of the AUIPC
                    regs_m[rd] = word_t'((prog_len - 1) * 4) + {uimm, 12'b0};
                end
            end
            3'd5: add_data_store(rs2);
            3'd6: begin
                // Walk to a word already stored in this test
                idx = dmem_addr_t'(next_bits(8));
                repeat (DMEM_WORDS) begin
                    if (!dmem_ok[idx]) begin
                        idx = idx + 1'b1;
                    end
                end
                if (dmem_ok[idx]) begin
                    emit(enc_i({2'b00, idx, 2'b00}, 5'd0, F3_WORD, rd, OPC_LOAD), rd, 5'd0, 5'd0);
                    regs_m[rd] = dmem_m[idx];
                end else begin
                    add_data_store(rs2);
                end
            end
            default: begin
                imm = {6'b0, 4'(next_bits(4)), 2'b00};
                if (next_bits(1) != 0) begin
                    emit(enc_i(imm, 5'd31, F3_WORD, rd, OPC_LOAD), rd, 5'd31, 5'd0);
                    regs_m[rd] = io_val;
                end else begin
                    add_io_store(rs2, imm);
                end
            end
        endcase
    endtask

    task automatic build_program();
        logic [11:0] imm;
        prog_len = 0;
        hist0    = '0;
        hist1    = '0;
        foreach (regs_m[i]) regs_m[i] = '0;
        foreach (dmem_ok[i]) dmem_ok[i] = 1'b0;
        // IO base into x31
        emit(enc_u(IO_BASE[31:12], 5'd31, OPC_LUI), 5'd31, 5'd0, 5'd0);
        regs_m[31] = IO_BASE;
        // Known start values for x1..x30
        for (int r = 1; r <= 30; r++) begin
            imm = 12'(next_bits(12));
            emit(enc_i(imm, 5'd0, F3_ADD_SUB, reg_idx_t'(r), OPC_OP_IMM), reg_idx_t'(r),
                 5'd0, 5'd0);
            regs_m[r] = sext12(imm);
        end
        repeat (BODY_LEN) add_random_instr();
        // Register dump to IO
        for (int r = 1; r <= 30; r++) begin
            add_io_store(reg_idx_t'(r), 12'(4 * r));
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////

    task automatic run_test(input int t);
        @(negedge CLOCK);
        RESET  = 1'b1;
        io_val = next_bits(32);
        exp_addr.delete();
        exp_data.delete();
        build_program();
        iobus_in = io_val;
        // Boot load, rest of the RAM filled with NOPs
        for (int k = 0; k < IMEM_WORDS; k++) begin
            @(negedge CLOCK);
            prog_we   = 1'b1;
            prog_addr = imem_addr_t'(k);
            prog_data = (k < prog_len) ? prog[k] : NOP;
        end
        @(negedge CLOCK);
        prog_we = 1'b0;
        RESET   = 1'b0;
        repeat (prog_len + 8) @(negedge CLOCK);
        if (exp_addr.size() != 0) begin
            abort_run($sformatf("Test %0d ended with %0d IO stores that never appeared",
                                t, exp_addr.size()));
        end
    endtask

    // Iobus monitor and cycle limit
    always @(posedge CLOCK) begin
        logic  was_reset;
        word_t a;
        word_t d;
        was_reset = reset_q;
        reset_q   = RESET;
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            abort_run("Timeout: the run went past its cycle limit");
        end else if (u_dut.u_props.failed) begin
            abort_run("An iobus assertion failed");
        end else if (RESET) begin
            // Pipeline cleared after one reset edge
            if (was_reset) begin
                check_strobe(iobus_wr, 1'b0);
            end
        end else if (iobus_wr !== 1'b0) begin
            if (exp_addr.size() == 0) begin
                abort_run("iobus_wr pulsed with no IO store expected");
            end else begin
                a = exp_addr.pop_front();
                d = exp_data.pop_front();
                check_addr(iobus_addr, a);
                check_data(iobus_out, d);
            end
        end
    end

    initial begin
        RESET     = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        iobus_in  = '0;
        cycles    = 0;
        reset_q   = 1'b0;
        repeat (3) @(negedge CLOCK);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        if (u_dut.u_props.failed) begin
            abort_run("An iobus assertion failed before the end of the run");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

/* verif/otter_pipeline_properties.sv */
module otter_pipeline_properties import otter_pipe_pkg::*; (
    input logic  CLOCK,
    input logic  RESET,
    input logic  iobus_wr,
    input word_t iobus_addr
);

    // Set once a reset edge has reached the pipeline registers
    logic armed = 1'b0;

    // Raised by any failing assertion
    logic failed = 1'b0;

    always @(posedge CLOCK) begin
        if (RESET) begin
            armed <= 1'b1;
        end
    end

    // No IO write while the core is held in reset
    a_no_wr_in_reset: assert property (@(posedge CLOCK) (armed && RESET) |-> !iobus_wr)
        else begin
            $error("iobus_wr high while RESET is high");
            failed = 1'b1;
        end

    // IO writes only inside the IO window, word aligned
    a_wr_addr_ok: assert property (@(posedge CLOCK)
        (armed && iobus_wr) |-> ((iobus_addr >= IO_BASE) && (iobus_addr[1:0] == 2'b00)))
        else begin
            $error("iobus_wr with address %h outside the IO window", iobus_addr);
            failed = 1'b1;
        end

    // Strobe always known once running
    a_wr_known: assert property (@(posedge CLOCK) (armed && !RESET) |-> !$isunknown(iobus_wr))
        else begin
            $error("iobus_wr is unknown after reset");
            failed = 1'b1;
        end

endmodule

/* source/otter_pipeline.sv */
module otter_pipeline import rv_isa_pkg::*, otter_pipe_pkg::*; (
    input  logic       CLOCK,
    input  logic       RESET,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  instr_t     prog_data,
    input  word_t      iobus_in,
    output word_t      iobus_out,
    output word_t      iobus_addr,
    output logic       iobus_wr
);

    ////////////////////////////////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////////////////////////////////

    fetch_t    fetch_q;
    decode_t   decode_q;
    exec_t     exec_q;
    // Writeback loops back into decode
    rf_write_t rf_write;

    // Memory stage to data RAM
    dmem_if dmem_bus ();

    fetch_stage u_fetch (
        .CLOCK     (CLOCK),
        .RESET     (RESET),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .fetch_out (fetch_q)
    );

    decode_stage u_decode (
        .CLOCK      (CLOCK),
        .RESET      (RESET),
        .fetch_in   (fetch_q),
        .rf_write   (rf_write),
        .decode_out (decode_q)
    );

    execute_stage u_execute (
        .CLOCK     (CLOCK),
        .RESET     (RESET),
        .decode_in (decode_q),
        .exec_out  (exec_q)
    );

    // Memory and writeback share one module
    mem_wb_stage u_mem_wb (
        .CLOCK      (CLOCK),
        .RESET      (RESET),
        .exec_in    (exec_q),
        .dmem       (dmem_bus.requester),
        .iobus_in   (iobus_in),
        .iobus_out  (iobus_out),
        .iobus_addr (iobus_addr),
        .iobus_wr   (iobus_wr),
        .rf_write   (rf_write)
    );

    data_memory u_dmem (
        .CLOCK (CLOCK),
        .dmem  (dmem_bus.memory)
    );

endmodule

/* source/data_memory.sv */
module data_memory import otter_pipe_pkg::*; (
    input  logic  CLOCK,
    dmem_if.memory dmem
);

    // Word RAM, no init
    word_t ram [DMEM_WORDS];

    // Word index from byte address
    dmem_addr_t idx;
    assign idx = dmem.addr[DMEM_AW+1:2];

    // Write port
    always_ff @(posedge CLOCK) begin
        if (dmem.we) begin
            ram[idx] <= dmem.wdata;
        end
    end

    // Read port, registered
    // old contents on a same-edge write
    always_ff @(posedge CLOCK) begin
        if (dmem.re) begin
            dmem.rdata <= ram[idx];
        end
    end

endmodule

/* source/mem_wb_stage.sv */
module mem_wb_stage import rv_isa_pkg::*, otter_pipe_pkg::*; (
    input  logic          CLOCK,
    input  logic          RESET,
    input  exec_t         exec_in,
    dmem_if.requester     dmem,
    input  word_t         iobus_in,
    output word_t         iobus_out,
    output word_t         iobus_addr,
    output logic          iobus_wr,
    output rf_write_t     rf_write
);

    ////////////////////////////////////////////////////////////////////
    // Memory stage
    ////////////////////////////////////////////////////////////////////

    // Single IO window compare
    logic is_io;
    assign is_io = (exec_in.result >= IO_BASE);

    // IO bus follows the memory-stage slot
    assign iobus_addr = exec_in.result;
    assign iobus_out  = exec_in.store_data;
    assign iobus_wr   = exec_in.valid && exec_in.mem_write && is_io;

    // Data RAM requests below the IO window
    assign dmem.addr  = exec_in.result;
    assign dmem.wdata = exec_in.store_data;
    assign dmem.we    = exec_in.valid && exec_in.mem_write && !is_io;
    assign dmem.re    = exec_in.valid && exec_in.mem_read && !is_io;

    // Memory register
    logic     wb_reg_write;
    reg_idx_t wb_rd;
    word_t    wb_result;
    wb_sel_t  wb_sel;
    logic     wb_io;
    word_t    wb_io_data;

    always_ff @(posedge CLOCK) begin
        wb_rd      <= exec_in.rd;
        wb_result  <= exec_in.result;
        wb_sel     <= exec_in.wb_sel;
        wb_io      <= is_io;
        // IO load data, sampled at end of memory stage
        wb_io_data <= iobus_in;
        if (RESET) begin
            wb_reg_write <= 1'b0;
        end else begin
            wb_reg_write <= exec_in.valid && exec_in.reg_write;
        end
    end

    // Writeback select, RAM data arrives this cycle
    assign rf_write.we   = wb_reg_write;
    assign rf_write.rd   = wb_rd;
    assign rf_write.data = (wb_sel == WB_LOAD) ? (wb_io ? wb_io_data : dmem.rdata)
                                               : wb_result;

endmodule

/* source/execute_stage.sv */
module execute_stage import rv_isa_pkg::*, otter_pipe_pkg::*; (
    input  logic    CLOCK,
    input  logic    RESET,
    input  decode_t decode_in,
    output exec_t   exec_out
);

    // ALU operands
    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu_result;

    assign op_a  = decode_in.op_a;
    assign op_b  = decode_in.op_b;
    // Shift amount, low five bits only
    assign shamt = op_b[4:0];

    // ALU
    always_comb begin
        case (decode_in.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_SLL:    alu_result = op_a << shamt;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SRL:    alu_result = op_a >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:    alu_result = word_t'($signed(op_a) >>> shamt);
            ALU_OR:     alu_result = op_a | op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // Execute register
    always_ff @(posedge CLOCK) begin
        exec_out.result     <= alu_result;
        exec_out.store_data <= decode_in.store_data;
        exec_out.rd         <= decode_in.rd;
        exec_out.wb_sel     <= decode_in.wb_sel;
        if (RESET) begin
            exec_out.valid     <= 1'b0;
            exec_out.reg_write <= 1'b0;
            exec_out.mem_write <= 1'b0;
            exec_out.mem_read  <= 1'b0;
        end else begin
            exec_out.valid     <= decode_in.valid;
            exec_out.reg_write <= decode_in.reg_write;
            exec_out.mem_write <= decode_in.mem_write;
            exec_out.mem_read  <= decode_in.mem_read;
        end
    end

endmodule

/* source/decode_stage.sv */
module decode_stage import rv_isa_pkg::*, otter_pipe_pkg::*; (
    input  logic      CLOCK,
    input  logic      RESET,
    input  fetch_t    fetch_in,
    input  rf_write_t rf_write,
    output decode_t   decode_out
);

    // Instruction fields
    instr_t     instr;
    opcode_t    opcode;
    logic [2:0] funct3;
    logic       alt_bit;
    assign instr   = fetch_in.instr;
    assign opcode  = opcode_t'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign alt_bit = instr[F7_ALT_BIT];

    // Register reads
    word_t rs1_data;
    word_t rs2_data;

    register_file u_regs (
        .CLOCK    (CLOCK),
        .rs1      (instr[19:15]),
        .rs2      (instr[24:20]),
        .rf_write (rf_write),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // Immediates, I, S and U forms
    word_t imm_i;
    word_t imm_s;
    word_t imm_u;
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    // funct3 plus alt bit to ALU operation
    function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            F3_AND:     return ALU_AND;
            default:    return ALU_ADD;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Main decoder and operand select
    ////////////////////////////////////////////////////////////////////

    decode_t dec;
    logic    known;

    always_comb begin
        dec            = '0;
        dec.alu_op     = ALU_ADD;
        dec.op_a       = rs1_data;
        dec.op_b       = rs2_data;
        dec.store_data = rs2_data;
        dec.rd         = instr[11:7];
        dec.wb_sel     = WB_ALU;
        known          = 1'b1;
        case (opcode)
            OPC_OP: begin
                dec.alu_op    = funct_to_alu(funct3, alt_bit);
                dec.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                // Bit 30 is immediate data except on SRAI
                dec.alu_op    = funct_to_alu(funct3, alt_bit && (funct3 == F3_SRL_SRA));
                dec.op_b      = imm_i;
                dec.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                // Word only, funct3 not looked at
                dec.op_b      = imm_i;
                dec.mem_read  = 1'b1;
                dec.reg_write = 1'b1;
                dec.wb_sel    = WB_LOAD;
            end
            OPC_STORE: begin
                dec.op_b      = imm_s;
                dec.mem_write = 1'b1;
            end
            OPC_LUI: begin
                dec.alu_op    = ALU_PASS_B;
                dec.op_b      = imm_u;
                dec.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                // Own pc, not pc+4
                dec.op_a      = fetch_in.pc;
                dec.op_b      = imm_u;
                dec.reg_write = 1'b1;
            end
            default: known = 1'b0;
        endcase
        dec.valid = fetch_in.valid && known;
        // Bubbles and unknown opcodes carry no side effects
        if (!dec.valid) begin
            dec.reg_write = 1'b0;
            dec.mem_write = 1'b0;
            dec.mem_read  = 1'b0;
        end
    end

    // Decode register
    always_ff @(posedge CLOCK) begin
        decode_out <= dec;
        if (RESET) begin
            decode_out.valid     <= 1'b0;
            decode_out.reg_write <= 1'b0;
            decode_out.mem_write <= 1'b0;
            decode_out.mem_read  <= 1'b0;
        end
    end

endmodule

/* source/register_file.sv */
module register_file import rv_isa_pkg::*, otter_pipe_pkg::*; (
    input  logic      CLOCK,
    input  reg_idx_t  rs1,
    input  reg_idx_t  rs2,
    input  rf_write_t rf_write,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    // x1..x31, x0 entry never written
    word_t regs [32];

    // Read ports with write-through
    // Same-cycle write to the read register wins
    assign rs1_data = (rs1 == '0) ? '0 :
                      (rf_write.we && (rf_write.rd == rs1)) ? rf_write.data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (rf_write.we && (rf_write.rd == rs2)) ? rf_write.data : regs[rs2];

    // Write port, end of writeback
    always_ff @(posedge CLOCK) begin
        if (rf_write.we && (rf_write.rd != '0)) begin
            regs[rf_write.rd] <= rf_write.data;
        end
    end

endmodule

/* source/fetch_stage.sv */
module fetch_stage import rv_isa_pkg::*, otter_pipe_pkg::*; (
    input  logic       CLOCK,
    input  logic       RESET,
    input  logic       prog_we,
    input  imem_addr_t prog_addr,
    input  instr_t     prog_data,
    output fetch_t     fetch_out
);

    // Instruction RAM
    instr_t imem [IMEM_WORDS];

    // Program counter and its word index
    word_t      pc;
    imem_addr_t pc_idx;

    assign pc_idx = pc[IMEM_AW+1:2];

    // Boot load port
    // Only open while the core is held in reset
    always_ff @(posedge CLOCK) begin
        if (RESET && prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // PC, no branches so it just counts
    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            pc <= '0;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // Fetch register
    // RAM read lands here directly, one cycle latency
    always_ff @(posedge CLOCK) begin
        fetch_out.pc    <= pc;
        fetch_out.instr <= imem[pc_idx];
        if (RESET) begin
            fetch_out.valid <= 1'b0;
        end else begin
            // Every slot after reset is a real fetch
            fetch_out.valid <= 1'b1;
        end
    end

endmodule

/* source/dmem_if.sv */
interface dmem_if import otter_pipe_pkg::*; ();

    // Byte address, word aligned
    word_t addr;
    // Store data
    word_t wdata;
    // Write and read strobes, one cycle each
    logic  we;
    logic  re;
    // Read data, valid the cycle after re
    word_t rdata;

    // Memory-stage side
    modport requester (
        output addr, wdata, we, re,
        input  rdata
    );

    // RAM side
    modport memory (
        input  addr, wdata, we, re,
        output rdata
    );

endinterface

/* source/otter_pipe_pkg.sv */
package otter_pipe_pkg;
    import rv_isa_pkg::*;

    // One data word
    typedef logic [XLEN-1:0] word_t;

    // Memory sizes in words
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // Word indexes into the two RAMs
    typedef logic [IMEM_AW-1:0] imem_addr_t;
    typedef logic [DMEM_AW-1:0] dmem_addr_t;

    // IO window, everything from here up
    localparam word_t IO_BASE = 32'h1100_0000;

    // Writeback source
    typedef enum logic {
        WB_ALU  = 1'b0,
        WB_LOAD = 1'b1
    } wb_sel_t;

    ////////////////////////////////////////////////////////////////////
    // Pipeline registers
    ////////////////////////////////////////////////////////////////////

    // Fetch to decode
    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_t instr;
    } fetch_t;

    // Decode to execute, operands already selected
    typedef struct packed {
        logic     valid;
        alu_op_t  alu_op;
        word_t    op_a;
        word_t    op_b;
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_write;
        logic     mem_read;
        wb_sel_t  wb_sel;
    } decode_t;

    // Execute to memory
    typedef struct packed {
        logic     valid;
        word_t    result;
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_write;
        logic     mem_read;
        wb_sel_t  wb_sel;
    } exec_t;

    // Writeback into the register file
    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } rf_write_t;

endpackage

/* source/rv_isa_pkg.sv */
package rv_isa_pkg;

    // Data path width
    localparam int XLEN = 32;

    // Raw instruction word and register number
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes of the kept subset
    // anything else in bits 6:0 decodes as a NOP
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_t;

    // funct3 codes, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Instruction bit 30 (funct7[5]) selects SUB and SRA
    localparam int F7_ALT_BIT = 30;

    // ALU operations
    // Encoding is {alt bit, funct3}, pass-B sits in a free slot
    typedef enum logic [3:0] {
        ALU_ADD    = 4'b0000,
        ALU_SUB    = 4'b1000,
        ALU_SLL    = 4'b0001,
        ALU_SLT    = 4'b0010,
        ALU_SLTU   = 4'b0011,
        ALU_XOR    = 4'b0100,
        ALU_SRL    = 4'b0101,
        ALU_SRA    = 4'b1101,
        ALU_OR     = 4'b0110,
        ALU_AND    = 4'b0111,
        // Operand B straight through, for LUI
        ALU_PASS_B = 4'b1001
    } alu_op_t;

endpackage
